//--- rtl/dbg_pkg.sv
`default_nettype none

package dbg_pkg;

    // dmi address width as reported in dtmcs
    localparam int DMI_ABITS = 7;

    typedef enum logic [3:0] {
        TAP_RESET,
        TAP_IDLE,
        TAP_SELECT_DR,
        TAP_CAPTURE_DR,
        TAP_SHIFT_DR,
        TAP_EXIT1_DR,
        TAP_PAUSE_DR,
        TAP_EXIT2_DR,
        TAP_UPDATE_DR,
        TAP_SELECT_IR,
        TAP_CAPTURE_IR,
        TAP_SHIFT_IR,
        TAP_EXIT1_IR,
        TAP_PAUSE_IR,
        TAP_EXIT2_IR,
        TAP_UPDATE_IR
    } tap_state_e;

    typedef enum logic [1:0] {
        DMI_NOP   = 2'd0,
        DMI_READ  = 2'd1,
        DMI_WRITE = 2'd2
    } dmi_op_e;

    typedef enum logic [DMI_ABITS-1:0] {
        DM_DMCONTROL  = 7'h10,
        DM_DMSTATUS   = 7'h11,
        DM_SBCS       = 7'h38,
        DM_SBADDRESS0 = 7'h39,
        DM_SBDATA0    = 7'h3c
    } dm_addr_e;

    // same bit order as the dmi shift register
    typedef struct packed {
        logic [DMI_ABITS-1:0] addr;
        logic [31:0]          data;
        dmi_op_e              op;
    } dmi_req_t;

    typedef struct packed {
        logic [31:0] data;
    } dmi_rsp_t;

endpackage

`default_nettype wire

//--- rtl/sbus_pkg.sv
`default_nettype none

package sbus_pkg;

    // one 32-bit word per request
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        wr;
    } sbus_req_t;

    // err marks an address outside the memory
    typedef struct packed {
        logic [31:0] rdata;
        logic        err;
    } sbus_rsp_t;

endpackage

`default_nettype wire

//--- rtl/jtag_tap.sv
`timescale 1ns/100ps
`default_nettype none

module jtag_tap #(
    parameter logic [31:0] IDCODE = 32'h0000_0001
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              tck,
    input  logic              tms,
    input  logic              tdi,
    output logic              tdo,
    output dbg_pkg::dmi_req_t dmi_req,
    output logic              dmi_req_valid,
    input  dbg_pkg::dmi_rsp_t dmi_rsp,
    input  logic              dmi_rsp_valid
);
    import dbg_pkg::*;

    localparam int DR_W = DMI_ABITS + 34;

    typedef enum logic [4:0] {
        IR_IDCODE = 5'h01,
        IR_DTMCS  = 5'h10,
        IR_DMI    = 5'h11
    } ir_e;

    // idle hint 1, abits, version 0.13
    localparam logic [31:0] DTMCS = {17'b0, 3'd1, 2'b00, 6'(DMI_ABITS), 4'd1};

    logic                 tck_q;
    logic                 tck_rise;
    logic                 tck_fall;
    tap_state_e           state;
    tap_state_e           state_next;
    ir_e                  ir;
    logic [4:0]           ir_shift;
    logic [DR_W-1:0]      dr;
    logic [DR_W-1:0]      dr_capture;
    dmi_op_e              dr_op;
    logic                 dmi_fire;
    logic [DMI_ABITS-1:0] last_addr;
    logic [31:0]          last_data;

    // tck edges as seen in the clk domain
    assign tck_rise = tck && !tck_q;
    assign tck_fall = !tck && tck_q;

    assign dr_op = dmi_op_e'(dr[1:0]);
    assign dmi_fire = tck_rise && state == TAP_UPDATE_DR && ir == IR_DMI &&
                      (dr_op == DMI_READ || dr_op == DMI_WRITE);

    always_comb begin
        case (state)
            TAP_RESET:      state_next = tms ? TAP_RESET     : TAP_IDLE;
            TAP_IDLE:       state_next = tms ? TAP_SELECT_DR : TAP_IDLE;
            TAP_SELECT_DR:  state_next = tms ? TAP_SELECT_IR : TAP_CAPTURE_DR;
            TAP_CAPTURE_DR: state_next = tms ? TAP_EXIT1_DR  : TAP_SHIFT_DR;
            TAP_SHIFT_DR:   state_next = tms ? TAP_EXIT1_DR  : TAP_SHIFT_DR;
            TAP_EXIT1_DR:   state_next = tms ? TAP_UPDATE_DR : TAP_PAUSE_DR;
            TAP_PAUSE_DR:   state_next = tms ? TAP_EXIT2_DR  : TAP_PAUSE_DR;
            TAP_EXIT2_DR:   state_next = tms ? TAP_UPDATE_DR : TAP_SHIFT_DR;
            TAP_UPDATE_DR:  state_next = tms ? TAP_SELECT_DR : TAP_IDLE;
            TAP_SELECT_IR:  state_next = tms ? TAP_RESET     : TAP_CAPTURE_IR;
            TAP_CAPTURE_IR: state_next = tms ? TAP_EXIT1_IR  : TAP_SHIFT_IR;
            TAP_SHIFT_IR:   state_next = tms ? TAP_EXIT1_IR  : TAP_SHIFT_IR;
            TAP_EXIT1_IR:   state_next = tms ? TAP_UPDATE_IR : TAP_PAUSE_IR;
            TAP_PAUSE_IR:   state_next = tms ? TAP_EXIT2_IR  : TAP_PAUSE_IR;
            TAP_EXIT2_IR:   state_next = tms ? TAP_UPDATE_IR : TAP_SHIFT_IR;
            TAP_UPDATE_IR:  state_next = tms ? TAP_SELECT_DR : TAP_IDLE;
            default:        state_next = TAP_RESET;
        endcase
    end

    // capture values, unknown instructions fall back to bypass
    always_comb begin
        case (ir)
            IR_IDCODE: dr_capture = DR_W'(IDCODE);
            IR_DTMCS:  dr_capture = DR_W'(DTMCS);
            // op field reads back as result 0, always success
            IR_DMI:    dr_capture = {last_addr, last_data, 2'b00};
            default:   dr_capture = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tck_q         <= 1'b0;
            state         <= TAP_RESET;
            ir            <= IR_IDCODE;
            tdo           <= 1'b0;
            dmi_req_valid <= 1'b0;
        end else begin
            tck_q         <= tck;
            dmi_req_valid <= dmi_fire;
            if (tck_rise) begin
                state <= state_next;
                if (state == TAP_RESET) begin
                    ir <= IR_IDCODE;
                end else if (state == TAP_UPDATE_IR) begin
                    ir <= ir_e'(ir_shift);
                end
            end
            // tdo changes on the falling edge only
            if (tck_fall) begin
                case (state)
                    TAP_SHIFT_IR: tdo <= ir_shift[0];
                    TAP_SHIFT_DR: tdo <= dr[0];
                    default:      tdo <= 1'b0;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dmi_rsp_valid) begin
            last_data <= dmi_rsp.data;
        end
        if (dmi_fire) begin
            dmi_req.addr <= dr[DR_W-1:34];
            dmi_req.data <= dr[33:2];
            dmi_req.op   <= dr_op;
            last_addr    <= dr[DR_W-1:34];
        end
        if (tck_rise) begin
            case (state)
                TAP_CAPTURE_IR: ir_shift <= 5'b00001;
                TAP_SHIFT_IR:   ir_shift <= {tdi, ir_shift[4:1]};
                TAP_CAPTURE_DR: dr <= dr_capture;
                TAP_SHIFT_DR: begin
                    // shift length follows the selected register
                    case (ir)
                        IR_DMI:              dr <= {tdi, dr[DR_W-1:1]};
                        IR_IDCODE, IR_DTMCS: dr[31:0] <= {tdi, dr[31:1]};
                        default:             dr[0] <= tdi;
                    endcase
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/dbg_module.sv
`timescale 1ns/100ps
`default_nettype none

module dbg_module #(
    parameter logic [19:0] HART_ID = 20'd0
) (
    input  logic                clk,
    input  logic                rst,
    input  dbg_pkg::dmi_req_t   dmi_req,
    input  logic                dmi_req_valid,
    output dbg_pkg::dmi_rsp_t   dmi_rsp,
    output logic                dmi_rsp_valid,
    output logic                haltreq,
    output logic                resumereq,
    input  logic                halted,
    output sbus_pkg::sbus_req_t sbus_req,
    output logic                sbus_req_valid,
    input  sbus_pkg::sbus_rsp_t sbus_rsp,
    input  logic                sbus_rsp_valid
);
    import dbg_pkg::*;

    dm_addr_e    reg_addr;
    logic        dmi_wr;
    logic        dmi_rd;
    logic [31:0] wdata;
    logic [31:0] rdata;

    logic        dmactive;
    logic        haltreq_q;
    logic        resumereq_q;
    logic [19:0] hartsel;
    logic        hart_match;
    logic        allresumeack;

    logic        sbreadonaddr;
    logic        sbbusy;
    logic [2:0]  sberror;
    logic [31:0] sbaddress0;
    logic [31:0] sbdata0;
    logic        sb_go;
    logic        sb_write;

    logic [31:0] dmcontrol;
    logic [31:0] dmstatus;
    logic [31:0] sbcs;

    assign reg_addr = dm_addr_e'(dmi_req.addr);
    assign dmi_wr   = dmi_req_valid && dmi_req.op == DMI_WRITE;
    assign dmi_rd   = dmi_req_valid && dmi_req.op == DMI_READ;
    assign wdata    = dmi_req.data;

    // field keeps hartsello in its upper half, swap back for the id
    assign hart_match = {hartsel[9:0], hartsel[19:10]} == HART_ID;
    assign haltreq    = dmactive && hart_match && haltreq_q;
    assign resumereq  = dmactive && hart_match && resumereq_q;

    assign dmcontrol = {haltreq_q, resumereq_q, 4'b0, hartsel, 5'b0, dmactive};

    // sbversion 1, 32-bit access only, 32-bit addresses
    assign sbcs = {3'd1, 7'b0, sbbusy, sbreadonaddr, 3'd2, 2'b0, sberror, 7'd32, 5'b00100};

    always_comb begin
        // authenticated, version 0.13
        dmstatus = 32'h0000_0082;
        if (hart_match) begin
            dmstatus[17:16] = {2{allresumeack}};
            dmstatus[11:10] = {2{!halted}};
            dmstatus[9:8]   = {2{halted}};
        end else begin
            dmstatus[15:14] = 2'b11;
        end
    end

    always_comb begin
        case (reg_addr)
            DM_DMCONTROL:  rdata = dmcontrol;
            DM_DMSTATUS:   rdata = dmstatus;
            DM_SBCS:       rdata = sbcs;
            DM_SBADDRESS0: rdata = sbaddress0;
            DM_SBDATA0:    rdata = sbdata0;
            default:       rdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dmi_rsp_valid  <= 1'b0;
            dmactive       <= 1'b0;
            haltreq_q      <= 1'b0;
            resumereq_q    <= 1'b0;
            hartsel        <= '0;
            allresumeack   <= 1'b0;
            sbreadonaddr   <= 1'b0;
            sbbusy         <= 1'b0;
            sberror        <= '0;
            sb_go          <= 1'b0;
            sbus_req_valid <= 1'b0;
        end else begin
            dmi_rsp_valid  <= dmi_req_valid;
            sb_go          <= 1'b0;
            sbus_req_valid <= sb_go;
            if (sb_go) begin
                sbbusy <= 1'b1;
            end
            if (sbus_rsp_valid) begin
                sbbusy <= 1'b0;
                if (sbus_rsp.err) begin
                    sberror <= 3'd2;
                end
            end
            // hart has left the halted state after a resume request
            if (resumereq && !halted) begin
                allresumeack <= 1'b1;
            end
            if (dmi_wr) begin
                case (reg_addr)
                    DM_DMCONTROL: begin
                        if (!dmactive || !wdata[0]) begin
                            // inactive module takes only dmactive
                            dmactive    <= wdata[0];
                            haltreq_q   <= 1'b0;
                            resumereq_q <= 1'b0;
                            hartsel     <= '0;
                        end else begin
                            haltreq_q   <= wdata[31];
                            resumereq_q <= wdata[30];
                            hartsel     <= wdata[25:6];
                            if (wdata[30]) begin
                                allresumeack <= 1'b0;
                            end
                        end
                    end
                    DM_SBCS: begin
                        sbreadonaddr <= wdata[20];
                        sberror      <= sberror & ~wdata[14:12];
                    end
                    DM_SBADDRESS0: sb_go <= sbreadonaddr;
                    DM_SBDATA0:    sb_go <= 1'b1;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        dmi_rsp.data <= dmi_rd ? rdata : '0;
        if (dmi_wr && reg_addr == DM_SBADDRESS0) begin
            sbaddress0 <= wdata;
            sb_write   <= 1'b0;
        end
        if (dmi_wr && reg_addr == DM_SBDATA0) begin
            sbdata0  <= wdata;
            sb_write <= 1'b1;
        end else if (sbus_rsp_valid && !sb_write) begin
            sbdata0 <= sbus_rsp.rdata;
        end
        // bus request one cycle after the register write
        if (sb_go) begin
            sbus_req.addr  <= sbaddress0;
            sbus_req.wdata <= sbdata0;
            sbus_req.wr    <= sb_write;
        end
    end

endmodule

`default_nettype wire

//--- rtl/sbus_mem.sv
`timescale 1ns/100ps
`default_nettype none

module sbus_mem #(
    parameter logic [31:0] MEM_BASE  = 32'h0100_0000,
    parameter int          MEM_WORDS = 1024
) (
    input  logic                clk,
    input  logic                rst,
    input  sbus_pkg::sbus_req_t sbus_req,
    input  logic                sbus_req_valid,
    output sbus_pkg::sbus_rsp_t sbus_rsp,
    output logic                sbus_rsp_valid
);
    localparam int          IDX_W     = $clog2(MEM_WORDS);
    localparam logic [31:0] MEM_BYTES = 32'(MEM_WORDS * 4);

    logic [31:0]      mem [MEM_WORDS];
    logic [31:0]      offset;
    logic             in_range;
    logic [IDX_W-1:0] idx;

    // addresses below the base wrap to large offsets
    assign offset   = sbus_req.addr - MEM_BASE;
    assign in_range = offset < MEM_BYTES;
    assign idx      = offset[IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            sbus_rsp_valid <= 1'b0;
        end else begin
            sbus_rsp_valid <= sbus_req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (sbus_req_valid) begin
            if (in_range && sbus_req.wr) begin
                mem[idx] <= sbus_req.wdata;
            end
            // writes and errors return zero data
            sbus_rsp.rdata <= (in_range && !sbus_req.wr) ? mem[idx] : '0;
            sbus_rsp.err   <= !in_range;
        end
    end

endmodule

`default_nettype wire

//--- rtl/dbg_top.sv
`timescale 1ns/100ps
`default_nettype none

module dbg_top #(
    parameter logic [31:0] IDCODE    = 32'h0dbe_a001,
    parameter logic [19:0] HART_ID   = 20'd1,
    parameter logic [31:0] MEM_BASE  = 32'h0100_0000,
    parameter int          MEM_WORDS = 1024
) (
    input  logic clk,
    input  logic rst,
    input  logic tck,
    input  logic tms,
    input  logic tdi,
    output logic tdo,
    output logic haltreq,
    output logic resumereq,
    input  logic halted
);
    import dbg_pkg::*;
    import sbus_pkg::*;

    dmi_req_t  dmi_req;
    logic      dmi_req_valid;
    dmi_rsp_t  dmi_rsp;
    logic      dmi_rsp_valid;
    sbus_req_t sbus_req;
    logic      sbus_req_valid;
    sbus_rsp_t sbus_rsp;
    logic      sbus_rsp_valid;

    jtag_tap #(
        .IDCODE (IDCODE)
    ) jtag_tap_i (
        .clk           (clk),
        .rst           (rst),
        .tck           (tck),
        .tms           (tms),
        .tdi           (tdi),
        .tdo           (tdo),
        .dmi_req       (dmi_req),
        .dmi_req_valid (dmi_req_valid),
        .dmi_rsp       (dmi_rsp),
        .dmi_rsp_valid (dmi_rsp_valid)
    );

    dbg_module #(
        .HART_ID (HART_ID)
    ) dbg_module_i (
        .clk            (clk),
        .rst            (rst),
        .dmi_req        (dmi_req),
        .dmi_req_valid  (dmi_req_valid),
        .dmi_rsp        (dmi_rsp),
        .dmi_rsp_valid  (dmi_rsp_valid),
        .haltreq        (haltreq),
        .resumereq      (resumereq),
        .halted         (halted),
        .sbus_req       (sbus_req),
        .sbus_req_valid (sbus_req_valid),
        .sbus_rsp       (sbus_rsp),
        .sbus_rsp_valid (sbus_rsp_valid)
    );

    sbus_mem #(
        .MEM_BASE  (MEM_BASE),
        .MEM_WORDS (MEM_WORDS)
    ) sbus_mem_i (
        .clk            (clk),
        .rst            (rst),
        .sbus_req       (sbus_req),
        .sbus_req_valid (sbus_req_valid),
        .sbus_rsp       (sbus_rsp),
        .sbus_rsp_valid (sbus_rsp_valid)
    );

endmodule

`default_nettype wire

//--- verif/jtag_tasks.svh
`ifndef JTAG_TASKS_SVH
`define JTAG_TASKS_SVH

// shadow copy of the bus memory
logic [31:0] shadow_mem [MEM_WORDS];

// one tck period of 8 clk with tdo taken just before the rising edge
task automatic tck_cycle(input logic tms_val, input logic tdi_val, output logic tdo_val);
    tms = tms_val;
    tdi = tdi_val;
    repeat (4) @(negedge clk);
    tdo_val = tdo;
    tck = 1'b1;
    repeat (4) @(negedge clk);
    tck = 1'b0;
endtask

// five edges with tms high, then on to run-test/idle
task automatic tap_reset();
    logic tdo_bit;
    repeat (5) tck_cycle(1'b1, 1'b0, tdo_bit);
    tck_cycle(1'b0, 1'b0, tdo_bit);
endtask

task automatic scan_ir(input logic [4:0] ir_val);
    logic       tdo_bit;
    logic [4:0] shift_in;
    shift_in = ir_val;
    // select-dr, select-ir, capture-ir, shift-ir
    tck_cycle(1'b1, 1'b0, tdo_bit);
    tck_cycle(1'b1, 1'b0, tdo_bit);
    tck_cycle(1'b0, 1'b0, tdo_bit);
    tck_cycle(1'b0, 1'b0, tdo_bit);
    for (int i = 0; i < 5; i++) begin
        tck_cycle(i == 4, shift_in[0], tdo_bit);
        shift_in = shift_in >> 1;
    end
    // update-ir, then idle
    tck_cycle(1'b1, 1'b0, tdo_bit);
    tck_cycle(1'b0, 1'b0, tdo_bit);
endtask

// lsb first with the captured bits returned in dout
task automatic scan_dr(input int len, input logic [63:0] din, output logic [63:0] dout);
    logic        tdo_bit;
    logic [63:0] shift_in;
    shift_in = din;
    dout = '0;
    tck_cycle(1'b1, 1'b0, tdo_bit);
    tck_cycle(1'b0, 1'b0, tdo_bit);
    tck_cycle(1'b0, 1'b0, tdo_bit);
    for (int i = 0; i < len; i++) begin
        tck_cycle(i == len - 1, shift_in[0], tdo_bit);
        shift_in = shift_in >> 1;
        dout = {tdo_bit, dout[63:1]};
    end
    dout = dout >> (64 - len);
    tck_cycle(1'b1, 1'b0, tdo_bit);
    tck_cycle(1'b0, 1'b0, tdo_bit);
endtask

task automatic dmi_scan(input logic [6:0] addr, input logic [31:0] data, input logic [1:0] op,
                        output logic [63:0] dout);
    scan_dr(41, {23'b0, addr, data, op}, dout);
    check_value("dmi op result", {30'b0, dout[1:0]}, 32'h0);
endtask

task automatic dmi_write(input logic [6:0] addr, input logic [31:0] data);
    logic [63:0] dout;
    dmi_scan(addr, data, 2'd2, dout);
endtask

// read request, then a nop scan to collect the result
task automatic dmi_read(input logic [6:0] addr, output logic [31:0] data);
    logic [63:0] dout;
    dmi_scan(addr, 32'h0, 2'd1, dout);
    dmi_scan(addr, 32'h0, 2'd0, dout);
    check_value("dmi address", {25'b0, dout[40:34]}, {25'b0, addr});
    data = dout[33:2];
endtask

// word address between the base and the last word of the memory
function automatic logic in_memory(input logic [31:0] addr);
    return addr >= MEM_BASE && addr < MEM_BASE + MEM_BYTES;
endfunction

function automatic void shadow_store(input logic [31:0] addr, input logic [31:0] data);
    if (in_memory(addr)) begin
        shadow_mem[(addr - MEM_BASE) / 4] = data;
    end
endfunction

// error flag in bit 32 and zero data outside the memory
function automatic logic [32:0] expected_word(input logic [31:0] addr);
    if (!in_memory(addr)) begin
        return {1'b1, 32'h0};
    end
    return {1'b0, shadow_mem[(addr - MEM_BASE) / 4]};
endfunction

`endif

//--- verif/dbg_tb.sv
`timescale 1ns/100ps
`default_nettype none

module dbg_tb;
    import dbg_pkg::*;

    localparam logic [31:0] IDCODE    = 32'h1dbe_a001;
    localparam logic [19:0] HART_ID   = 20'h5_3a7;
    localparam logic [31:0] MEM_BASE  = 32'h0100_0000;
    localparam int          MEM_WORDS = 1024;
    localparam logic [31:0] MEM_BYTES = 32'(MEM_WORDS * 4);
    localparam int          SB_TRIALS = 8;

    localparam logic [4:0]  IR_DTMCS = 5'h10;
    localparam logic [4:0]  IR_DMI   = 5'h11;

    // debug register bits
    localparam logic [31:0] HALTREQ      = 32'h8000_0000;
    localparam logic [31:0] RESUMEREQ    = 32'h4000_0000;
    localparam logic [31:0] DMACTIVE     = 32'h0000_0001;
    localparam logic [31:0] ALLHALTED    = 32'h0000_0200;
    localparam logic [31:0] ALLRESUMEACK = 32'h0002_0000;
    localparam logic [31:0] SBREADONADDR = 32'h0010_0000;
    localparam logic [31:0] SBERROR_ONES = 32'h0000_7000;

    logic clk = 1'b0;
    logic rst;
    logic tck;
    logic tms;
    logic tdi;
    logic tdo;
    logic haltreq;
    logic resumereq;
    logic halted;

    int          errors;
    int          tests;
    int          failed_tests;
    int          errors_at_start;
    string       test_name;
    string       name_q[$];
    logic [31:0] got_q[$];
    logic [31:0] exp_q[$];

    dbg_top #(
        .IDCODE    (IDCODE),
        .HART_ID   (HART_ID),
        .MEM_BASE  (MEM_BASE),
        .MEM_WORDS (MEM_WORDS)
    ) dbg_top_i (
        .clk       (clk),
        .rst       (rst),
        .tck       (tck),
        .tms       (tms),
        .tdi       (tdi),
        .tdo       (tdo),
        .haltreq   (haltreq),
        .resumereq (resumereq),
        .halted    (halted)
    );

    always #5 clk = ~clk;

    // hands a result to the compare process
    function automatic void check_value(input string name, input logic [31:0] got,
                                        input logic [31:0] expected);
        name_q.push_back(name);
        got_q.push_back(got);
        exp_q.push_back(expected);
    endfunction

    always @(negedge clk) begin
        string       name;
        logic [31:0] got;
        logic [31:0] expected;
        while (exp_q.size() > 0) begin
            name = name_q.pop_front();
            got = got_q.pop_front();
            expected = exp_q.pop_front();
            assert (got === expected) else begin
                $display("error at %0d ns: %s expected 0x%08h, got 0x%08h",
                         $time, name, expected, got);
                errors++;
            end
        end
    end

    `include "jtag_tasks.svh"

    // hartsello in bits 25:16, hartselhi in bits 15:6
    function automatic logic [31:0] hartsel_field(input logic [19:0] id);
        return {6'b0, id[9:0], id[19:10], 6'b0};
    endfunction

    task automatic start_test(input string name);
        tests++;
        test_name = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        int guard;
        guard = 0;
        while (exp_q.size() > 0 && guard < 10) begin
            @(negedge clk);
            guard++;
        end
        if (exp_q.size() > 0) begin
            $display("checks of test %0d were never compared", tests);
            errors++;
        end
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", tests, test_name);
        end else begin
            $display("test %0d %s: %0d errors", tests, test_name, errors - errors_at_start);
            failed_tests++;
        end
    endtask

    task automatic wait_for_haltreq();
        int cycles;
        cycles = 0;
        while (haltreq !== 1'b1 && cycles < 100) begin
            @(negedge clk);
            cycles++;
        end
        if (haltreq !== 1'b1) begin
            $display("timeout waiting for haltreq to rise");
            errors++;
        end
    endtask

    task automatic poll_dmstatus(input logic [31:0] mask, output logic [31:0] status);
        int reads;
        reads = 0;
        dmi_read(DM_DMSTATUS, status);
        while ((status & mask) == 32'h0 && reads < 10) begin
            dmi_read(DM_DMSTATUS, status);
            reads++;
        end
        if ((status & mask) == 32'h0) begin
            $display("timeout polling dmstatus for bits 0x%08h", mask);
            errors++;
        end
    endtask

    // sbbusy must be clear once the poll ends
    task automatic wait_sb_idle(output logic [31:0] sbcs);
        int reads;
        reads = 0;
        dmi_read(DM_SBCS, sbcs);
        while (sbcs[21] && reads < 10) begin
            dmi_read(DM_SBCS, sbcs);
            reads++;
        end
        check_value("sbcs.sbbusy", {31'b0, sbcs[21]}, 32'h0);
    endtask

    // hart model halting and resuming after a random delay
    initial begin
        int delay;
        halted = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst && haltreq && !halted) begin
                delay = 5 + int'($urandom % 16);
                repeat (delay) @(negedge clk);
                halted = 1'b1;
            end else if (!rst && resumereq && halted) begin
                delay = 5 + int'($urandom % 16);
                repeat (delay) @(negedge clk);
                halted = 1'b0;
            end
        end
    end

    initial begin
        logic        tdo_bit;
        logic [63:0] dout;
        logic [31:0] rd;
        logic [31:0] sbcs;
        logic [31:0] addr;
        logic [31:0] wd;
        logic [31:0] high_cycles;
        logic [32:0] ref_word;
        logic [31:0] sb_addrs[$];
        logic [31:0] bad_addrs[2];
        int unsigned word_idx;

        void'($urandom(87602));
        errors = 0;
        tests = 0;
        failed_tests = 0;
        rst = 1'b1;
        tck = 1'b0;
        tms = 1'b1;
        tdi = 1'b0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        start_test("idcode and dtmcs");
        tck_cycle(1'b0, 1'b0, tdo_bit);
        scan_dr(32, 64'h0, dout);
        check_value("idcode", dout[31:0], IDCODE);
        scan_ir(IR_DTMCS);
        scan_dr(32, 64'h0, dout);
        check_value("dtmcs.abits", {26'b0, dout[9:4]}, 32'd7);
        check_value("dtmcs.idle", {29'b0, dout[14:12]}, 32'd1);
        check_value("dtmcs.version", {28'b0, dout[3:0]}, 32'd1);
        // tap reset brings back the idcode instruction
        tap_reset();
        scan_dr(32, 64'h0, dout);
        check_value("idcode", dout[31:0], IDCODE);
        end_test();

        start_test("dmactive gating");
        scan_ir(IR_DMI);
        dmi_write(DM_DMCONTROL, HALTREQ | hartsel_field(HART_ID));
        check_value("haltreq", {31'b0, haltreq}, 32'h0);
        dmi_read(DM_DMCONTROL, rd);
        check_value("dmcontrol", rd, 32'h0);
        check_value("haltreq", {31'b0, haltreq}, 32'h0);
        dmi_write(DM_DMCONTROL, DMACTIVE);
        dmi_write(DM_DMCONTROL, hartsel_field(HART_ID) | DMACTIVE);
        dmi_read(DM_DMCONTROL, rd);
        check_value("dmcontrol", rd, hartsel_field(HART_ID) | DMACTIVE);
        end_test();

        start_test("halt and resume");
        dmi_write(DM_DMCONTROL, HALTREQ | hartsel_field(HART_ID) | DMACTIVE);
        wait_for_haltreq();
        poll_dmstatus(ALLHALTED, rd);
        check_value("dmstatus.allhalted", {31'b0, rd[9]}, 32'h1);
        dmi_write(DM_DMCONTROL, RESUMEREQ | hartsel_field(HART_ID) | DMACTIVE);
        check_value("resumereq", {31'b0, resumereq}, 32'h1);
        poll_dmstatus(ALLRESUMEACK, rd);
        check_value("dmstatus.allresumeack", {31'b0, rd[17]}, 32'h1);
        check_value("dmstatus.allhalted", {31'b0, rd[9]}, 32'h0);
        end_test();

        start_test("hartsel mismatch");
        dmi_write(DM_DMCONTROL, HALTREQ | hartsel_field(HART_ID ^ 20'h1) | DMACTIVE);
        high_cycles = 32'h0;
        for (int i = 0; i < 200; i++) begin
            @(negedge clk);
            if (haltreq) begin
                high_cycles++;
            end
        end
        check_value("haltreq high cycles", high_cycles, 32'h0);
        end_test();

        start_test("system bus access");
        dmi_write(DM_SBCS, SBREADONADDR);
        for (int i = 0; i < SB_TRIALS; i++) begin
            word_idx = $urandom % MEM_WORDS;
            addr = MEM_BASE + (word_idx << 2);
            wd = $urandom;
            dmi_write(DM_SBADDRESS0, addr);
            dmi_write(DM_SBDATA0, wd);
            shadow_store(addr, wd);
            wait_sb_idle(sbcs);
            sb_addrs.push_back(addr);
        end
        foreach (sb_addrs[i]) begin
            ref_word = expected_word(sb_addrs[i]);
            dmi_write(DM_SBADDRESS0, sb_addrs[i]);
            wait_sb_idle(sbcs);
            check_value("sbcs.sberror", {29'b0, sbcs[14:12]}, ref_word[32] ? 32'd2 : 32'd0);
            dmi_read(DM_SBDATA0, rd);
            check_value("sbdata0", rd, ref_word[31:0]);
        end
        end_test();

        start_test("bus error");
        // just past the end and just below the base
        bad_addrs[0] = MEM_BASE + MEM_BYTES;
        bad_addrs[1] = MEM_BASE - 32'd4;
        foreach (bad_addrs[i]) begin
            ref_word = expected_word(bad_addrs[i]);
            dmi_write(DM_SBADDRESS0, bad_addrs[i]);
            wait_sb_idle(sbcs);
            check_value("sbcs.sberror", {29'b0, sbcs[14:12]}, ref_word[32] ? 32'd2 : 32'd0);
            dmi_read(DM_SBDATA0, rd);
            check_value("sbdata0", rd, ref_word[31:0]);
            dmi_write(DM_SBCS, SBREADONADDR | SBERROR_ONES);
            dmi_read(DM_SBCS, sbcs);
            check_value("sbcs.sberror", {29'b0, sbcs[14:12]}, 32'd0);
        end
        end_test();

        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests, failed_tests, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dbg_sys.f
+incdir+verif
rtl/dbg_pkg.sv
rtl/sbus_pkg.sv
rtl/jtag_tap.sv
rtl/dbg_module.sv
rtl/sbus_mem.sv
rtl/dbg_top.sv
verif/dbg_tb.sv

//--- run.sh
#!/bin/sh
# build the testbench with verilator, run it, and check its verdict
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module dbg_tb -f dbg_sys.f -o dbg_sim \
    && sim_out=$(./obj_dir/dbg_sim) \
    || { echo "build or simulation run failed"; exit 1; }

echo "$sim_out"
echo "$sim_out" | grep -qx '>>> PASS' && echo "simulation passed" \
    || { echo "simulation reported failure"; exit 1; }
